//--- router.f
+incdir+common
common/router_pkg.sv
logic/flit_fifo.sv
router/port_link.sv
router/rx_arbiter.sv
router/tx_dispatch.sv
router/router.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_router.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_router -f router.f -o tb_router_sim \
	&& ./obj_dir/tb_router_sim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

//--- tb/tb_router.sv
`default_nettype none

`include "router_defines.svh"

module tb_router;

	typedef struct packed {
		logic [3:0] group;
		router_pkg::port_idx_t src;
		router_pkg::port_idx_t dest; // expected output port is flit mod 5
		router_pkg::flit_t flit;
		logic [7:0] delay; // tx ack delay in cycles
	} stim_row_t;

	localparam int n_groups = 8;
	localparam int bp_group = 7;
	localparam int wait_limit = 2000;
	localparam int drain_limit = 4000;

	logic clk;
	logic rst = 1'b1;
	router_pkg::link_t [`ROUTER_PORTS-1:0] rx = '0;
	router_pkg::port_mask_t rx_ack;
	router_pkg::link_t [`ROUTER_PORTS-1:0] tx;
	router_pkg::port_mask_t tx_ack = '0;
	router_pkg::flit_t table_addr;
	router_pkg::port_idx_t table_port;
	logic bp_active = 1'b0;
	int errors;
	int pending;

	stim_row_t stim [64];
	int n_rows;
	int seed;
	int timeouts;
	int ack_delay [`ROUTER_PORTS];
	int ack_cnt [`ROUTER_PORTS];

	tb_clock clkgen (.clk(clk));

	router uut (
		.clk(clk),
		.rst(rst),
		.rx(rx),
		.rx_ack(rx_ack),
		.tx(tx),
		.tx_ack(tx_ack),
		.table_addr(table_addr),
		.table_port(table_port)
	);

	tb_checker chk (
		.clk(clk),
		.rst(rst),
		.rx(rx),
		.rx_ack(rx_ack),
		.tx(tx),
		.tx_ack(tx_ack),
		.bp_active(bp_active),
		.errors(errors),
		.pending(pending)
	);

	// routing table model
	assign table_port = router_pkg::port_idx_t'(table_addr % `ROUTER_PORTS);

	// output acks rise after the configured delay and fall once req drops
	always @(posedge clk) begin
		for (int p = 0; p < `ROUTER_PORTS; p++) begin
			if (rst) begin
				tx_ack[p] <= 1'b0;
				ack_cnt[p] <= 0;
			end else if (tx[p].req && !tx_ack[p]) begin
				if (ack_cnt[p] >= ack_delay[p]) begin
					tx_ack[p] <= 1'b1;
					ack_cnt[p] <= 0;
				end else begin
					ack_cnt[p] <= ack_cnt[p] + 1;
				end
			end else if (!tx[p].req && tx_ack[p]) begin
				tx_ack[p] <= 1'b0;
			end
		end
	end

	task automatic add_row(int g, int src, router_pkg::flit_t flit, int delay);
		stim[n_rows].group = 4'(g);
		stim[n_rows].src = router_pkg::port_idx_t'(src);
		stim[n_rows].dest = router_pkg::port_idx_t'(flit % `ROUTER_PORTS);
		stim[n_rows].flit = flit;
		stim[n_rows].delay = 8'(delay);
		n_rows++;
	endtask

	task automatic build_table();
		for (int p = 0; p < `ROUTER_PORTS; p++)
			add_row(p, p, router_pkg::flit_t'($random(seed)), {$random(seed)} % 4);
		// ten flits on one input all bound for west
		for (int k = 0; k < 10; k++)
			add_row(5, 1, router_pkg::flit_t'(5 * ({$random(seed)} % 51) + 3), 1);
		for (int p = 0; p < `ROUTER_PORTS; p++)
			for (int k = 0; k < 3; k++)
				add_row(6, p, router_pkg::flit_t'($random(seed)), {$random(seed)} % 6);
		// 30 flits into a slow east port is more than the fifo holds
		for (int p = 0; p < `ROUTER_PORTS; p++)
			for (int k = 0; k < 6; k++)
				add_row(bp_group, p, router_pkg::flit_t'(5 * ({$random(seed)} % 51) + 2), 40);
	endtask

	task automatic note_timeout(string what);
		$display("timeout: %s", what);
		timeouts++;
	endtask

	task automatic send_rows(int p, int g);
		int t;
		for (int r = 0; r < n_rows; r++) begin
			if (int'(stim[r].group) == g && int'(stim[r].src) == p && timeouts == 0) begin
				ack_delay[stim[r].dest] <= int'(stim[r].delay);
				@(posedge clk);
				rx[p] <= {1'b1, stim[r].flit};
				t = 0;
				while (!rx_ack[p] && t < wait_limit) begin
					@(posedge clk);
					t++;
				end
				if (t >= wait_limit)
					note_timeout($sformatf("no rx ack on input %0d", p));
				rx[p].req <= 1'b0;
				t = 0;
				while (rx_ack[p] && t < wait_limit) begin
					@(posedge clk);
					t++;
				end
				if (t >= wait_limit)
					note_timeout($sformatf("rx ack stuck high on input %0d", p));
			end
		end
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while (pending != 0 && t < drain_limit) begin
			@(posedge clk);
			t++;
		end
		if (pending != 0)
			note_timeout($sformatf("%0d flits never left the router", pending));
	endtask

	initial begin
		seed = 32'hd1b9d6b4;
		n_rows = 0;
		timeouts = 0;
		for (int p = 0; p < `ROUTER_PORTS; p++)
			ack_delay[p] = 0;
		build_table();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk); // quiet window after reset
		for (int g = 0; g < n_groups && timeouts == 0; g++) begin
			bp_active <= (g == bp_group);
			fork
				send_rows(0, g);
				send_rows(1, g);
				send_rows(2, g);
				send_rows(3, g);
				send_rows(4, g);
			join
			wait_drained();
			bp_active <= 1'b0;
		end
		repeat (4) @(posedge clk);
		$display("summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_checker.sv
`default_nettype none

`include "router_defines.svh"

module tb_checker (
	input logic clk,
	input logic rst,
	input router_pkg::link_t [`ROUTER_PORTS-1:0] rx,
	input router_pkg::port_mask_t rx_ack,
	input router_pkg::link_t [`ROUTER_PORTS-1:0] tx,
	input router_pkg::port_mask_t tx_ack,
	input logic bp_active,
	output int errors,
	output int pending
);

	// one queue per input and output pair since order only holds within a pair
	router_pkg::flit_t exp_q [`ROUTER_PORTS*`ROUTER_PORTS][$];
	router_pkg::link_t [`ROUTER_PORTS-1:0] rx_prev;
	router_pkg::link_t [`ROUTER_PORTS-1:0] tx_prev;
	router_pkg::port_mask_t rx_ack_prev;
	router_pkg::port_mask_t tx_ack_prev;
	logic seen_rx_req;
	logic bp_prev;
	int stall [`ROUTER_PORTS];
	int stall_max;

	// number of four-phase violations on one link
	function automatic int link_rule(router_pkg::link_t cur, router_pkg::link_t prev,
		logic ack, logic ack_prev, string side, int p);
		int n;
		n = 0;
		if (cur.req && !prev.req && ack) begin
			$display("FAILED %0t: %s req on port %0d rose while ack high", $time, side, p);
			n++;
		end
		if (cur.req && prev.req && cur.flit != prev.flit) begin
			$display("FAILED %0t: %s flit on port %0d changed while req high", $time, side, p);
			n++;
		end
		if (ack && !ack_prev && !cur.req) begin
			$display("FAILED %0t: %s ack on port %0d rose without req", $time, side, p);
			n++;
		end
		if (!ack && ack_prev && cur.req) begin
			$display("FAILED %0t: %s ack on port %0d fell while req high", $time, side, p);
			n++;
		end
		return n;
	endfunction

	always @(posedge clk) begin
		int err_n;
		int pend_n;
		int smax;
		int k;
		logic found;
		err_n = errors;
		pend_n = pending;
		smax = stall_max;
		if (rst) begin
			err_n = 0;
			pend_n = 0;
			smax = 0;
			seen_rx_req <= 1'b0;
			for (int p = 0; p < `ROUTER_PORTS; p++)
				stall[p] <= 0;
		end else begin
			if (bp_active && !bp_prev)
				smax = 0;
			for (int p = 0; p < `ROUTER_PORTS; p++) begin
				if (rx[p].req)
					seen_rx_req <= 1'b1;
				if (!seen_rx_req && (tx[p].req || rx_ack[p])) begin
					$display("FAILED %0t: port %0d active before any input req", $time, p);
					err_n++;
				end
				err_n += link_rule(rx[p], rx_prev[p], rx_ack[p], rx_ack_prev[p], "rx", p);
				err_n += link_rule(tx[p], tx_prev[p], tx_ack[p], tx_ack_prev[p], "tx", p);
				if (rx_ack[p] && !rx_ack_prev[p]) begin
					exp_q[p * `ROUTER_PORTS + int'(rx[p].flit) % `ROUTER_PORTS].push_back(rx[p].flit);
					pend_n++;
				end
				if (tx[p].req && !tx_prev[p].req) begin
					found = 1'b0;
					for (int i = 0; i < `ROUTER_PORTS; i++) begin
						k = i * `ROUTER_PORTS + p;
						if (!found && exp_q[k].size() > 0 && exp_q[k][0] == tx[p].flit) begin
							void'(exp_q[k].pop_front());
							found = 1'b1;
						end
					end
					if (found) begin
						pend_n--;
					end else begin
						$display("FAILED %0t: flit %h not expected on port %0d", $time,
							tx[p].flit, p);
						err_n++;
					end
				end
				if (rx[p].req && !rx_ack[p])
					stall[p] <= stall[p] + 1;
				else
					stall[p] <= 0;
				if (bp_active && stall[p] > smax)
					smax = stall[p];
			end
			if (!bp_active && bp_prev && smax <= 40) begin
				$display("input acks never stalled during the back-pressure test");
				err_n++;
			end
		end
		errors <= err_n;
		pending <= pend_n;
		stall_max <= smax;
		rx_prev <= rx;
		tx_prev <= tx;
		rx_ack_prev <= rx_ack;
		tx_ack_prev <= tx_ack;
		bp_prev <= bp_active;
	end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 unit period
	end

endmodule

`default_nettype wire

//--- router/router.sv
`default_nettype none

`include "router_defines.svh"

module router (
	input logic clk,
	input logic rst,
	input router_pkg::link_t [`ROUTER_PORTS-1:0] rx,
	output router_pkg::port_mask_t rx_ack,
	output router_pkg::link_t [`ROUTER_PORTS-1:0] tx,
	input router_pkg::port_mask_t tx_ack,
	output router_pkg::flit_t table_addr,
	input router_pkg::port_idx_t table_port
);

	router_pkg::link_t [`ROUTER_PORTS-1:0] rx_links; // input buffers -> arbiter
	router_pkg::port_mask_t rx_links_ack;
	router_pkg::link_t [`ROUTER_PORTS-1:0] tx_links; // dispatcher -> output buffers
	router_pkg::port_mask_t tx_links_ack;

	logic fifo_write;
	logic fifo_read;
	logic fifo_full;
	logic fifo_empty;
	router_pkg::flit_t fifo_din;
	router_pkg::flit_t fifo_dout;

	for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_rx
		port_link rx_link (
			.clk(clk),
			.rst(rst),
			.up(rx[i]),
			.up_ack(rx_ack[i]),
			.down(rx_links[i]),
			.down_ack(rx_links_ack[i])
		);
	end

	rx_arbiter arb (
		.clk(clk),
		.rst(rst),
		.links(rx_links),
		.link_ack(rx_links_ack),
		.fifo_full(fifo_full),
		.fifo_write(fifo_write),
		.fifo_din(fifo_din)
	);

	// single shared queue, head-of-line blocking is expected
	flit_fifo fifo (
		.clk(clk),
		.rst(rst),
		.write(fifo_write),
		.din(fifo_din),
		.read(fifo_read),
		.dout(fifo_dout),
		.full(fifo_full),
		.empty(fifo_empty)
	);

	tx_dispatch disp (
		.clk(clk),
		.rst(rst),
		.fifo_empty(fifo_empty),
		.fifo_dout(fifo_dout),
		.fifo_read(fifo_read),
		.table_addr(table_addr),
		.table_port(table_port),
		.links(tx_links),
		.link_ack(tx_links_ack)
	);

	for (genvar j = 0; j < `ROUTER_PORTS; j++) begin : g_tx
		port_link tx_link (
			.clk(clk),
			.rst(rst),
			.up(tx_links[j]),
			.up_ack(tx_links_ack[j]),
			.down(tx[j]),
			.down_ack(tx_ack[j])
		);
	end

endmodule

`default_nettype wire

//--- router/tx_dispatch.sv
`default_nettype none

`include "router_defines.svh"

module tx_dispatch (
	input logic clk,
	input logic rst,
	input logic fifo_empty,
	input router_pkg::flit_t fifo_dout,
	output logic fifo_read,
	output router_pkg::flit_t table_addr,
	input router_pkg::port_idx_t table_port,
	output router_pkg::link_t [`ROUTER_PORTS-1:0] links,
	input router_pkg::port_mask_t link_ack
);

	router_pkg::disp_state_e state;
	router_pkg::flit_t flit_q;
	router_pkg::port_idx_t port_q;
	logic req_q;

	// table sees the head during lookup, the held flit otherwise
	assign table_addr = (state == router_pkg::lookup) ? fifo_dout : flit_q;
	assign fifo_read = state == router_pkg::lookup;

	always_comb begin
		for (int i = 0; i < `ROUTER_PORTS; i++) begin
			links[i].req = req_q && (port_q == router_pkg::port_idx_t'(i));
			links[i].flit = flit_q;
		end
	end

	always_ff @(posedge clk) begin
		if (state == router_pkg::lookup) begin
			flit_q <= fifo_dout;
			port_q <= table_port;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= router_pkg::idle;
			req_q <= 1'b0;
		end else begin
			case (state)
				router_pkg::idle: begin
					if (!fifo_empty)
						state <= router_pkg::lookup;
				end
				router_pkg::lookup: begin
					// previous delivery ended with ack low, so req may rise now
					req_q <= 1'b1;
					state <= router_pkg::deliver;
				end
				router_pkg::deliver: begin
					if (req_q && link_ack[port_q])
						req_q <= 1'b0;
					else if (!req_q && !link_ack[port_q])
						state <= router_pkg::idle; // handshake complete
				end
				default: begin
					state <= router_pkg::idle;
					req_q <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- router/rx_arbiter.sv
`default_nettype none

`include "router_defines.svh"

module rx_arbiter (
	input logic clk,
	input logic rst,
	input router_pkg::link_t [`ROUTER_PORTS-1:0] links,
	output router_pkg::port_mask_t link_ack,
	input logic fifo_full,
	output logic fifo_write,
	output router_pkg::flit_t fifo_din
);

	router_pkg::port_idx_t ptr; // search starts here
	router_pkg::port_idx_t grant_idx;
	logic grant_valid;

	// port index plus an offset, wrapped at the port count
	function automatic router_pkg::port_idx_t wrap_add(router_pkg::port_idx_t base,
		int unsigned step);
		int unsigned sum;
		sum = base + step;
		if (sum >= `ROUTER_PORTS)
			sum = sum - `ROUTER_PORTS;
		return router_pkg::port_idx_t'(sum);
	endfunction

	always_comb begin
		grant_valid = 1'b0;
		grant_idx = ptr;
		for (int k = 0; k < `ROUTER_PORTS; k++) begin
			if (!grant_valid && links[wrap_add(ptr, k)].req && !link_ack[wrap_add(ptr, k)]) begin
				grant_valid = 1'b1;
				grant_idx = wrap_add(ptr, k);
			end
		end
	end

	// write goes in on the same edge that raises the ack
	assign fifo_write = grant_valid && !fifo_full;
	assign fifo_din = links[grant_idx].flit;

	always_ff @(posedge clk) begin
		if (rst) begin
			link_ack <= '0;
			ptr <= router_pkg::port_north;
		end else begin
			for (int i = 0; i < `ROUTER_PORTS; i++) begin
				if (link_ack[i] && !links[i].req)
					link_ack[i] <= 1'b0; // phase 4
			end
			if (fifo_write) begin
				link_ack[grant_idx] <= 1'b1;
				ptr <= wrap_add(grant_idx, 1); // next search skips the winner
			end
		end
	end

endmodule

`default_nettype wire

//--- router/port_link.sv
`default_nettype none

module port_link (
	input logic clk,
	input logic rst,
	input router_pkg::link_t up,
	output logic up_ack,
	output router_pkg::link_t down,
	input logic down_ack
);

	router_pkg::flit_t data;
	logic full;
	logic sent; // downstream handshake done, waiting for ack to fall
	logic down_req;

	assign down.req = down_req;
	assign down.flit = data;

	always_ff @(posedge clk) begin
		if (!full && up.req && !up_ack)
			data <= up.flit;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
			sent <= 1'b0;
			up_ack <= 1'b0;
			down_req <= 1'b0;
		end else begin
			// upstream side
			if (!full && up.req && !up_ack) begin
				full <= 1'b1;
				up_ack <= 1'b1;
			end else if (up_ack && !up.req) begin
				up_ack <= 1'b0;
			end

			// replay downstream
			if (full && !sent && !down_req && !down_ack)
				down_req <= 1'b1;
			if (down_req && down_ack) begin
				down_req <= 1'b0;
				sent <= 1'b1;
			end
			if (sent && !down_ack) begin
				sent <= 1'b0;
				full <= 1'b0; // buffer free again
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/flit_fifo.sv
`default_nettype none

`include "router_defines.svh"

module flit_fifo (
	input logic clk,
	input logic rst,
	input logic write,
	input router_pkg::flit_t din,
	input logic read,
	output router_pkg::flit_t dout,
	output logic full,
	output logic empty
);

	localparam int depth = 1 << `ROUTER_FIFO_DEPTH_LOG2;

	router_pkg::flit_t mem [depth];
	logic [`ROUTER_FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [`ROUTER_FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [`ROUTER_FIFO_DEPTH_LOG2:0] count;
	logic do_write;
	logic do_read;

	assign do_write = write && !full;
	assign do_read = read && !empty;

	assign full = count[`ROUTER_FIFO_DEPTH_LOG2]; // msb only set at depth
	assign empty = count == '0;
	assign dout = mem[rd_ptr]; // head shows without a read

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- common/router_pkg.sv
`default_nettype none

`include "router_defines.svh"

package router_pkg;

	typedef logic [`ROUTER_FLIT_W-1:0] flit_t;
	typedef logic [`ROUTER_PORT_W-1:0] port_idx_t;
	typedef logic [`ROUTER_PORTS-1:0] port_mask_t;

	// port order matches the bit order of every mask and link array
	typedef enum port_idx_t {
		port_north = 3'd0,
		port_south = 3'd1,
		port_east = 3'd2,
		port_west = 3'd3,
		port_local = 3'd4
	} port_e;

	// forward half of a link, ack comes back on its own wire
	typedef struct packed {
		logic req;
		flit_t flit;
	} link_t;

	typedef enum logic [1:0] {
		idle,
		lookup,
		deliver
	} disp_state_e;

endpackage

`default_nettype wire

//--- common/router_defines.svh
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// flit width in bits, also the routing table address width
`define ROUTER_FLIT_W 8

// north, south, east, west, local
`define ROUTER_PORTS 5

// enough bits to name any port
`define ROUTER_PORT_W 3

// shared fifo holds 16 flits
`define ROUTER_FIFO_DEPTH_LOG2 4

`endif
